//--- hw/reduce_config.svh
`ifndef REDUCE_CONFIG_SVH
`define REDUCE_CONFIG_SVH

// payload carried by every flit, one word
`define RED_PAYLOAD_W 32

// one mesh coordinate and the full rank {z,y,x}
`define RED_COORD_W 3
`define RED_RANK_W 9

// header fields
`define RED_CTX_W 8
`define RED_TAG_W 8
`define RED_ALG_W 2
`define RED_OP_W 4

// children annotation added by the ingress stage
`define RED_CHILD_W 3

// ranks taking part in the reduction tree
`define RED_COMM_SIZE 8

// both FIFOs hold 1 << RED_FIFO_LG entries
`define RED_FIFO_LG 4

// table entries, picked by the low context id bits
`define RED_CTX_ENTRIES 4

// width of the dropped-flit counter
`define RED_CNT_W 16

`endif

//--- hw/reduce_pkg.sv
`include "reduce_config.svh"

package reduce_pkg;

  // reduction ops as carried in the op field
  typedef enum logic [`RED_OP_W-1:0] {
    OP_ADD = 4'd0,
    OP_MAX = 4'd1,
    OP_MIN = 4'd2,
    OP_AND = 4'd3,
    OP_OR  = 4'd4,
    OP_XOR = 4'd5
  } red_op_e;

  // wire format, valid bit at 72 down to payload at 31..0
  typedef struct packed {
    logic                      valid;
    logic [`RED_COORD_W-1:0]   dst_z;
    logic [`RED_COORD_W-1:0]   dst_y;
    logic [`RED_COORD_W-1:0]   dst_x;
    logic [`RED_COORD_W-1:0]   src_z;
    logic [`RED_COORD_W-1:0]   src_y;
    logic [`RED_COORD_W-1:0]   src_x;
    logic [`RED_CTX_W-1:0]     context_id;
    logic [`RED_TAG_W-1:0]     tag;
    logic [`RED_ALG_W-1:0]     algtype;
    red_op_e                   op;
    logic [`RED_PAYLOAD_W-1:0] payload;
  } flit_t;

  // buffered form with the local child count on top
  typedef struct packed {
    logic [`RED_CHILD_W-1:0] children;
    flit_t                   flit;
  } tagged_flit_t;

  // position of a rank in the tree, root sits at 0
  function automatic int unsigned rel_of(int unsigned rank, int unsigned root);
    return (rank + `RED_COMM_SIZE - (root % `RED_COMM_SIZE)) % `RED_COMM_SIZE;
  endfunction

  // binary tree, children of rel are 2*rel+1 and 2*rel+2
  function automatic int unsigned children_of(int unsigned rel);
    int unsigned n;
    n = 0;
    if (2 * rel + 1 < `RED_COMM_SIZE)
      n = n + 1;
    if (2 * rel + 2 < `RED_COMM_SIZE)
      n = n + 1;
    return n;
  endfunction

  // the root reports to itself
  function automatic int unsigned parent_of(int unsigned rank, int unsigned root);
    int unsigned rel;
    rel = rel_of(rank, root);
    if (rel == 0)
      return rank;
    return ((rel - 1) / 2 + root) % `RED_COMM_SIZE;
  endfunction

endpackage

//--- hw/tree_ingress.sv
`timescale 1ns/100ps
`include "reduce_config.svh"

module tree_ingress #(
  parameter logic [`RED_RANK_W-1:0] rank = '0,
  parameter logic [`RED_RANK_W-1:0] root = '0
) (
  input  logic                      clk,
  input  logic                      rst,
  input  reduce_pkg::flit_t         in_flit,
  input  logic                      in_wr,
  output logic                      in_full,
  input  logic [`RED_FIFO_LG:0]     fifo_count,
  output reduce_pkg::tagged_flit_t  ing_flit,
  output logic                      ing_wr,
  output logic [`RED_CNT_W-1:0]     drop_count
);
  import reduce_pkg::*;

  localparam int unsigned DEPTH = 1 << `RED_FIFO_LG;

  // child count is fixed by rank and root
  localparam logic [`RED_CHILD_W-1:0] CHILDREN =
    `RED_CHILD_W'(children_of(rel_of(rank, root)));

  logic [`RED_RANK_W-1:0] dst_rank;
  logic                   accept;

  // destination rank in {z,y,x} order
  assign dst_rank = {in_flit.dst_z, in_flit.dst_y, in_flit.dst_x};

  // only live flits for this rank go on
  assign accept = in_flit.valid && (dst_rank == rank);

  // two slots kept back, one for the flit in the ingress register
  // and one for a write in the same cycle
  assign in_full = (fifo_count >= (`RED_FIFO_LG+1)'(DEPTH - 2));

  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      ing_wr     <= 1'b0;
      drop_count <= '0;
    end
    else
    begin
      ing_wr <= in_wr && accept;
      // count every written flit that is filtered out
      if (in_wr && !accept)
        drop_count <= drop_count + 1'b1;
    end
  end

  // annotated flit, qualified by ing_wr
  always_ff @(posedge clk)
  begin
    if (in_wr)
    begin
      ing_flit.children <= CHILDREN;
      ing_flit.flit     <= in_flit;
    end
  end

endmodule

//--- hw/flit_fifo.sv
`timescale 1ns/100ps
`include "reduce_config.svh"

module flit_fifo #(
  parameter type payload_t = logic [7:0]
) (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  wr,
  input  payload_t              wr_data,
  output logic                  full,
  input  logic                  pop,
  output payload_t              rd_data,
  output logic                  empty,
  output logic [`RED_FIFO_LG:0] count
);

  localparam int unsigned DEPTH = 1 << `RED_FIFO_LG;

  payload_t                 mem [DEPTH];
  logic [`RED_FIFO_LG-1:0]  wr_ptr;
  logic [`RED_FIFO_LG-1:0]  rd_ptr;
  logic                     do_wr;
  logic                     do_rd;

  // flags come straight from the fill count
  assign empty = (count == '0);
  assign full  = (count == (`RED_FIFO_LG+1)'(DEPTH));

  // requests against full or empty are ignored
  assign do_wr = wr && !full;
  assign do_rd = pop && !empty;

  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end
    else
    begin
      // pointers wrap naturally at the depth
      if (do_wr)
        wr_ptr <= wr_ptr + 1'b1;
      if (do_rd)
        rd_ptr <= rd_ptr + 1'b1;
      // write and read together leave the count alone
      case ({do_wr, do_rd})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // storage and the registered read port
  always_ff @(posedge clk)
  begin
    if (do_wr)
      mem[wr_ptr] <= wr_data;
    if (do_rd)
      rd_data <= mem[rd_ptr];
  end

endmodule

//--- hw/reduction_table.sv
`timescale 1ns/100ps
`include "reduce_config.svh"

module reduction_table #(
  parameter logic [`RED_RANK_W-1:0] rank = '0,
  parameter logic [`RED_RANK_W-1:0] root = '0
) (
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      fifo_empty,
  output logic                      tbl_pop,
  input  reduce_pkg::tagged_flit_t  tbl_flit,
  input  logic                      out_full,
  output reduce_pkg::flit_t         res_flit,
  output logic                      res_wr
);
  import reduce_pkg::*;

  localparam int IDX_W = $clog2(`RED_CTX_ENTRIES);
  localparam int CW    = `RED_COORD_W;

  // where finished results are sent
  localparam logic [`RED_RANK_W-1:0] PARENT = `RED_RANK_W'(parent_of(rank, root));

  // table entries
  logic [`RED_CTX_ENTRIES-1:0] busy;
  logic [`RED_PAYLOAD_W-1:0]   acc      [`RED_CTX_ENTRIES];
  logic [`RED_CHILD_W-1:0]     arrivals [`RED_CTX_ENTRIES];
  flit_t                       hdr      [`RED_CTX_ENTRIES];

  // flit coming out of the input FIFO this cycle
  logic                        rd_vld;
  flit_t                       cur;
  logic [IDX_W-1:0]            idx;

  // next state of the addressed entry
  flit_t                       base;
  logic [`RED_PAYLOAD_W-1:0]   new_acc;
  logic [`RED_CHILD_W-1:0]     new_cnt;
  logic                        done;
  flit_t                       res_next;

  function automatic logic [`RED_PAYLOAD_W-1:0] combine(
    input red_op_e                   op,
    input logic [`RED_PAYLOAD_W-1:0] a,
    input logic [`RED_PAYLOAD_W-1:0] b
  );
    case (op)
      OP_ADD:  return a + b;
      OP_MAX:  return (a > b) ? a : b;
      OP_MIN:  return (a < b) ? a : b;
      OP_AND:  return a & b;
      OP_OR:   return a | b;
      OP_XOR:  return a ^ b;
      default: return a;
    endcase
  endfunction

  // one flit in flight at a time, so a pop never meets a full output
  // and an entry is never read while its update is pending
  assign tbl_pop = !fifo_empty && !out_full && !rd_vld && !res_wr;

  assign cur = tbl_flit.flit;
  assign idx = cur.context_id[IDX_W-1:0];

  always_comb
  begin
    if (busy[idx])
    begin
      // fold into the open context with the op of its first flit
      base    = hdr[idx];
      new_acc = combine(hdr[idx].op, acc[idx], cur.payload);
      new_cnt = arrivals[idx] + 1'b1;
    end
    else
    begin
      // first arrival opens the entry
      base    = cur;
      new_acc = cur.payload;
      new_cnt = `RED_CHILD_W'(1);
    end

    // own flit plus one per child; a leaf finishes at once
    done = (new_cnt == tbl_flit.children + 1'b1);

    // result heads up the tree
    res_next            = base;
    res_next.valid      = 1'b1;
    res_next.dst_z      = PARENT[2*CW +: CW];
    res_next.dst_y      = PARENT[CW +: CW];
    res_next.dst_x      = PARENT[0 +: CW];
    res_next.src_z      = rank[2*CW +: CW];
    res_next.src_y      = rank[CW +: CW];
    res_next.src_x      = rank[0 +: CW];
    res_next.payload    = new_acc;
  end

  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      rd_vld <= 1'b0;
      res_wr <= 1'b0;
      busy   <= '0;
    end
    else
    begin
      // read data is valid the cycle after the pop
      rd_vld <= tbl_pop;
      res_wr <= rd_vld && done;
      if (rd_vld)
        busy[idx] <= !done;
    end
  end

  // entry contents only matter while busy is set
  always_ff @(posedge clk)
  begin
    if (rd_vld)
    begin
      acc[idx]      <= new_acc;
      arrivals[idx] <= new_cnt;
      if (!busy[idx])
        hdr[idx] <= cur;
      if (done)
        res_flit <= res_next;
    end
  end

endmodule

//--- hw/reduce_node_top.sv
`timescale 1ns/100ps
`include "reduce_config.svh"

module reduce_node_top #(
  parameter logic [`RED_RANK_W-1:0] rank = '0,
  parameter logic [`RED_RANK_W-1:0] root = '0
) (
  input  logic                  clk,
  input  logic                  rst,
  input  reduce_pkg::flit_t     in_flit,
  input  logic                  in_wr,
  output logic                  in_full,
  output reduce_pkg::flit_t     out_flit,
  input  logic                  out_pop,
  output logic                  out_empty,
  output logic [`RED_CNT_W-1:0] drop_count
);
  import reduce_pkg::*;

  // ingress to input FIFO
  tagged_flit_t          ing_flit;
  logic                  ing_wr;
  logic [`RED_FIFO_LG:0] in_count;

  // input FIFO to table
  tagged_flit_t          tbl_flit;
  logic                  tbl_pop;
  logic                  in_empty;

  // table to output FIFO
  flit_t                 res_flit;
  logic                  res_wr;
  logic                  res_full;

  tree_ingress #(
    .rank (rank),
    .root (root)
  ) u_ingress (
    .clk        (clk),
    .rst        (rst),
    .in_flit    (in_flit),
    .in_wr      (in_wr),
    .in_full    (in_full),
    .fifo_count (in_count),
    .ing_flit   (ing_flit),
    .ing_wr     (ing_wr),
    .drop_count (drop_count)
  );

  // annotated flits wait here for the table
  flit_fifo #(
    .payload_t (tagged_flit_t)
  ) u_in_fifo (
    .clk     (clk),
    .rst     (rst),
    .wr      (ing_wr),
    .wr_data (ing_flit),
    .full    (),
    .pop     (tbl_pop),
    .rd_data (tbl_flit),
    .empty   (in_empty),
    .count   (in_count)
  );

  reduction_table #(
    .rank (rank),
    .root (root)
  ) u_table (
    .clk        (clk),
    .rst        (rst),
    .fifo_empty (in_empty),
    .tbl_pop    (tbl_pop),
    .tbl_flit   (tbl_flit),
    .out_full   (res_full),
    .res_flit   (res_flit),
    .res_wr     (res_wr)
  );

  // results toward the parent
  flit_fifo #(
    .payload_t (flit_t)
  ) u_out_fifo (
    .clk     (clk),
    .rst     (rst),
    .wr      (res_wr),
    .wr_data (res_flit),
    .full    (res_full),
    .pop     (out_pop),
    .rd_data (out_flit),
    .empty   (out_empty),
    .count   ()
  );

endmodule

//--- verification/reduce_asserts.sv
`timescale 1ns/100ps
`include "reduce_config.svh"

module reduce_asserts (
  input logic                  clk,
  input logic                  rst,
  input logic                  wr,
  input logic                  full,
  input logic                  pop,
  input logic                  empty,
  input logic [`RED_FIFO_LG:0] count
);

  localparam int unsigned DEPTH = 1 << `RED_FIFO_LG;

  // fill count stays within the buffer
  a_count_range: assert property (@(posedge clk) disable iff (rst) count <= DEPTH)
    else $error("fifo count above depth");

  // upstream must respect full
  a_no_write_full: assert property (@(posedge clk) disable iff (rst) !(wr && full))
    else $error("fifo written while full");

  // downstream must respect empty
  a_no_pop_empty: assert property (@(posedge clk) disable iff (rst) !(pop && empty))
    else $error("fifo popped while empty");

  a_flags_exclusive: assert property (@(posedge clk) disable iff (rst) !(empty && full))
    else $error("fifo empty and full together");

endmodule

// every FIFO instance gets its own checker
bind flit_fifo reduce_asserts u_asserts (
  .clk   (clk),
  .rst   (rst),
  .wr    (wr),
  .full  (full),
  .pop   (pop),
  .empty (empty),
  .count (count)
);

//--- verification/reduce_checker.sv
`timescale 1ns/100ps
`include "reduce_config.svh"

module reduce_checker (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  in_full,
  input  reduce_pkg::flit_t     out_flit,
  input  logic                  out_pop,
  input  logic                  out_empty,
  input  logic [`RED_CNT_W-1:0] drop_count,
  output int                    error_count
);
  import reduce_pkg::*;

  flit_t                 expected_q [$];
  int                    test_id;
  int                    test_errors;
  int                    tests_run;
  int                    tests_failed;
  logic [`RED_CNT_W-1:0] drop_base;
  logic [`RED_CNT_W-1:0] drop_expected;
  logic                  pop_seen;

  initial
  begin
    error_count  = 0;
    test_errors  = 0;
    tests_run    = 0;
    tests_failed = 0;
    test_id      = 0;
  end

  // plain-words failure, counted against the current test
  task automatic flag_error(input string msg);
    $display("error at %0t ns in test %0d: %s", $time, test_id, msg);
    test_errors = test_errors + 1;
    error_count = error_count + 1;
  endtask

  task automatic check_field(input string name, input logic [31:0] exp,
                             input logic [31:0] act);
    if (exp !== act)
    begin
      $display("Fail at %0t ns: %s expected %h got %h", $time, name, exp, act);
      test_errors = test_errors + 1;
      error_count = error_count + 1;
    end
  endtask

  function automatic int pending();
    return expected_q.size();
  endfunction

  task automatic expect_flit(input flit_t f);
    expected_q.push_back(f);
  endtask

  task automatic expect_drops(input logic [`RED_CNT_W-1:0] n);
    drop_expected = n;
  endtask

  task automatic begin_test(input int id);
    test_id       = id;
    test_errors   = 0;
    drop_base     = drop_count;
    // no drops unless the data says so
    drop_expected = '0;
  endtask

  task automatic end_test();
    check_field("drop_count increase", 32'(drop_expected), 32'(drop_count - drop_base));
    if (expected_q.size() != 0)
      flag_error("expected results never came out");
    expected_q.delete();
    tests_run = tests_run + 1;
    if (test_errors == 0)
      $display("test %0d: passed", test_id);
    else
    begin
      tests_failed = tests_failed + 1;
      $display("test %0d: failed with %0d errors", test_id, test_errors);
    end
  endtask

  // idle state right after reset
  task automatic check_reset();
    check_field("out_empty", 32'(1), 32'(out_empty));
    check_field("in_full", 32'(0), 32'(in_full));
    check_field("drop_count", 32'(0), 32'(drop_count));
  endtask

  task automatic report_totals();
    $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, error_count);
  endtask

  // a pop at this edge gives data after it
  always @(posedge clk or posedge rst)
  begin
    if (rst)
      pop_seen <= 1'b0;
    else
      pop_seen <= out_pop && !out_empty;
  end

  // compare half a cycle later, out_flit is settled by then
  always @(negedge clk)
  begin
    flit_t exp;
    if (pop_seen)
    begin
      if (expected_q.size() == 0)
        flag_error("result flit popped with none expected");
      else
      begin
        exp = expected_q.pop_front();
        check_field("out_flit.valid", 32'(exp.valid), 32'(out_flit.valid));
        check_field("out_flit.dst", 32'({exp.dst_z, exp.dst_y, exp.dst_x}),
                    32'({out_flit.dst_z, out_flit.dst_y, out_flit.dst_x}));
        check_field("out_flit.src", 32'({exp.src_z, exp.src_y, exp.src_x}),
                    32'({out_flit.src_z, out_flit.src_y, out_flit.src_x}));
        check_field("out_flit.context_id", 32'(exp.context_id), 32'(out_flit.context_id));
        check_field("out_flit.tag", 32'(exp.tag), 32'(out_flit.tag));
        check_field("out_flit.algtype", 32'(exp.algtype), 32'(out_flit.algtype));
        check_field("out_flit.op", 32'(exp.op), 32'(out_flit.op));
        check_field("out_flit.payload", exp.payload, out_flit.payload);
      end
    end
  end

endmodule

//--- verification/reduce_tb.sv
`timescale 1ns/100ps
`include "reduce_config.svh"

module reduce_tb;
  import reduce_pkg::*;

  localparam int TIMEOUT = 2000;

  logic                  clk;
  logic                  rst;
  flit_t                 in_flit;
  logic                  in_wr;
  logic                  in_full;
  flit_t                 out_flit;
  logic                  out_pop;
  logic                  out_empty;
  logic [`RED_CNT_W-1:0] drop_count;
  int                    error_count;

  // popping control, cleared while back-pressure is wanted
  logic                  pop_en;
  logic                  hold;
  logic                  hold_test;
  logic                  saw_full;

  // set once a write could not get in, the rest of the data is skipped
  logic                  stalled;

  // rank 1 under root 0 has children 3 and 4, parent 0
  reduce_node_top #(
    .rank (9'd1),
    .root (9'd0)
  ) DUT (
    .clk        (clk),
    .rst        (rst),
    .in_flit    (in_flit),
    .in_wr      (in_wr),
    .in_full    (in_full),
    .out_flit   (out_flit),
    .out_pop    (out_pop),
    .out_empty  (out_empty),
    .drop_count (drop_count)
  );

  reduce_checker chk (
    .clk         (clk),
    .rst         (rst),
    .in_full     (in_full),
    .out_flit    (out_flit),
    .out_pop     (out_pop),
    .out_empty   (out_empty),
    .drop_count  (drop_count),
    .error_count (error_count)
  );

  initial
    clk = 1'b0;

  always #5 clk = ~clk;

  // reader side, pops whatever is waiting
  always @(negedge clk)
    out_pop = pop_en && !out_empty && !rst;

  function automatic flit_t make_flit(input logic v, input logic [8:0] dst,
                                      input logic [8:0] src, input logic [7:0] ctx,
                                      input logic [7:0] tag, input logic [1:0] alg,
                                      input logic [3:0] op, input logic [31:0] payload);
    flit_t f;
    f.valid      = v;
    {f.dst_z, f.dst_y, f.dst_x} = dst;
    {f.src_z, f.src_y, f.src_x} = src;
    f.context_id = ctx;
    f.tag        = tag;
    f.algtype    = alg;
    f.op         = red_op_e'(op);
    f.payload    = payload;
    return f;
  endfunction

  // one write, held back while in_full is up
  task automatic send_flit(input flit_t f);
    int waited;
    waited = 0;
    while (in_full && !stalled)
    begin
      // the stall was reached, let the reader drain again
      if (hold)
      begin
        saw_full = 1'b1;
        hold     = 1'b0;
        pop_en   = 1'b1;
      end
      if (waited == TIMEOUT)
      begin
        chk.flag_error("in_full stayed high and the flit was never sent");
        stalled = 1'b1;
      end
      else
      begin
        waited = waited + 1;
        @(negedge clk);
      end
    end
    if (!stalled)
    begin
      in_flit = f;
      in_wr   = 1'b1;
      @(negedge clk);
      in_wr   = 1'b0;
    end
  endtask

  task automatic wait_drained();
    int waited;
    waited = 0;
    // results still missing are reported by end_test
    while (chk.pending() != 0 && waited < TIMEOUT)
    begin
      waited = waited + 1;
      @(negedge clk);
    end
    // drop_count moves one cycle after the write
    // a stray result needs the five-cycle node latency to show up
    repeat (6) @(negedge clk);
  endtask

  // n contexts of add, each from self and both children
  task automatic send_burst(input logic [7:0] ctx0, input logic [7:0] tag, input int n);
    logic [8:0] srcs [3];
    srcs[0] = 9'd1;
    srcs[1] = 9'd3;
    srcs[2] = 9'd4;
    for (int i = 0; i < n; i++)
    begin
      chk.expect_flit(make_flit(1'b1, 9'd0, 9'd1, ctx0 + 8'(i), tag, 2'd0, OP_ADD,
                                32'(3 * (i + 1))));
      for (int s = 0; s < 3; s++)
        send_flit(make_flit(1'b1, 9'd1, srcs[s], ctx0 + 8'(i), tag, 2'd0, OP_ADD,
                            32'(i + 1)));
    end
  endtask

  initial
  begin
    int          fd;
    int          n;
    string       line;
    logic [31:0] kind;
    logic [31:0] test;
    logic [31:0] valid;
    logic [31:0] dst;
    logic [31:0] src;
    logic [31:0] ctx;
    logic [31:0] tag;
    logic [31:0] alg;
    logic [31:0] op;
    logic [31:0] payload;
    flit_t       f;

    rst       = 1'b1;
    in_flit   = '0;
    in_wr     = 1'b0;
    out_pop   = 1'b0;
    pop_en    = 1'b1;
    hold      = 1'b0;
    hold_test = 1'b0;
    saw_full  = 1'b0;
    stalled   = 1'b0;
    repeat (16) @(negedge clk);
    rst = 1'b0;
    @(negedge clk);

    chk.begin_test(1);
    chk.check_reset();
    chk.end_test();

    fd = $fopen("verification/reduce_testdata.txt", "r");
    if (fd == 0)
      chk.flag_error("test data file could not be opened");
    else
    begin
      while (!$feof(fd) && !stalled)
      begin
        line = "";
        void'($fgets(line, fd));
        if (line.len() < 2 || line.substr(0, 0) == "#")
          continue;
        n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h",
                    kind, test, valid, dst, src, ctx, tag, alg, op, payload);
        if (n != 10)
        begin
          chk.flag_error("malformed test data line");
          continue;
        end
        f = make_flit(valid[0], dst[8:0], src[8:0], ctx[7:0], tag[7:0], alg[1:0],
                      op[3:0], payload);
        case (kind)
          // test start, payload 1 asks for back-pressure
          0:
          begin
            chk.begin_test(int'(test));
            hold      = payload[0];
            hold_test = payload[0];
            pop_en    = !payload[0];
            saw_full  = 1'b0;
          end
          1: send_flit(f);
          2: chk.expect_flit(f);
          3: chk.expect_drops(payload[`RED_CNT_W-1:0]);
          4:
          begin
            pop_en = 1'b1;
            hold   = 1'b0;
            wait_drained();
            if (hold_test && !saw_full)
              chk.flag_error("in_full never rose while nothing was popped");
            chk.end_test();
          end
          6: send_burst(ctx[7:0], tag[7:0], int'(payload));
          default: chk.flag_error("unknown record kind in test data");
        endcase
      end
      $fclose(fd);
    end

    chk.report_totals();
    if (error_count == 0)
      $display("PASS: all tests");
    else
      $display("FAIL: see errors above");
    $finish;
  end

endmodule

//--- sources.f
+incdir+hw
hw/reduce_pkg.sv
hw/tree_ingress.sv
hw/flit_fifo.sv
hw/reduction_table.sv
hw/reduce_node_top.sv
verification/reduce_asserts.sv
verification/reduce_checker.sv
verification/reduce_tb.sv

//--- run_sim.sh
#!/bin/sh
# build and run the reduction node testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module reduce_tb \
  -f sources.f -o reduce_sim > build.log 2>&1 \
  && ./obj_dir/reduce_sim > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q "^PASS: all tests$" sim.log \
  && echo "simulation passed" \
  || { echo "simulation failed, see build.log and sim.log"; exit 1; }

//--- verification/reduce_testdata.txt
# kind test valid dst src ctx tag alg op payload, all hex, ranks as {z,y,x}
# kind 0 start (payload 1 = no popping), 1 input, 2 expected, 3 drops, 4 end, 6 burst
0 2 0 000 000 00 00 0 0 00000000
2 2 1 000 001 05 11 0 0 00000060
1 2 1 001 001 05 11 0 0 00000010
1 2 1 001 003 05 11 0 0 00000020
1 2 1 001 004 05 11 0 0 00000030
4 2 0 000 000 00 00 0 0 00000000
0 3 0 000 000 00 00 0 0 00000000
2 3 1 000 001 06 20 1 1 80000001
1 3 1 001 001 06 20 1 1 00000007
1 3 1 001 003 06 20 1 1 80000001
1 3 1 001 004 06 20 1 1 0000ffff
2 3 1 000 001 06 21 1 2 00000200
1 3 1 001 001 06 21 1 2 00000300
1 3 1 001 003 06 21 1 2 00000200
1 3 1 001 004 06 21 1 2 00000400
2 3 1 000 001 06 22 1 3 0f000f0f
1 3 1 001 001 06 22 1 3 ff00ff0f
1 3 1 001 003 06 22 1 3 0f0f0f0f
1 3 1 001 004 06 22 1 3 3f3f0f3f
2 3 1 000 001 06 23 1 4 00010011
1 3 1 001 001 06 23 1 4 00000001
1 3 1 001 003 06 23 1 4 00000010
1 3 1 001 004 06 23 1 4 00010000
2 3 1 000 001 06 24 1 5 ff0000ff
1 3 1 001 001 06 24 1 5 0000ffff
1 3 1 001 003 06 24 1 5 00ff00ff
1 3 1 001 004 06 24 1 5 ffffffff
4 3 0 000 000 00 00 0 0 00000000
0 4 0 000 000 00 00 0 0 00000000
2 4 1 000 001 04 31 2 5 00000009
2 4 1 000 001 03 30 2 0 00000007
1 4 1 001 001 03 30 2 0 00000001
1 4 1 001 001 04 31 2 5 00000005
1 4 1 001 003 03 30 2 0 00000002
1 4 1 001 003 04 31 2 5 00000003
1 4 1 001 004 04 31 2 5 0000000f
1 4 1 001 004 03 30 2 0 00000004
4 4 0 000 000 00 00 0 0 00000000
0 5 0 000 000 00 00 0 0 00000000
3 5 0 000 000 00 00 0 0 00000003
1 5 0 001 003 07 40 0 0 00000001
1 5 1 002 003 07 40 0 0 00000002
1 5 1 000 003 07 40 0 0 00000003
4 5 0 000 000 00 00 0 0 00000000
0 6 0 000 000 00 00 0 0 00000001
6 6 0 000 000 40 50 0 0 00000018
4 6 0 000 000 00 00 0 0 00000000
